// ==== test/tag_patterns.hex ====
// Kind nibble then 32 data bits; kind 0 is a trace word
// Kinds 1 to 4 are final client values, kind 5 is error_o
000000000
00230A5C3
002701234
002B0BEEF
004000005
002F08421
002430005
0022500FF
002ACFFFF
004000003
003707777
006000000
002F0FFFF
000000000
10000001F
200000000
300000FFF
400008421
500000001

// ==== flist.f ====
verilog/tag_pkg.sv
verilog/chip_cfg_pkg.sv
verilog/tag_trace_replay.sv
verilog/tag_master.sv
verilog/tag_client.sv
verilog/tag_chip_top.sv
test/tag_chip_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the tag chip testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tag_chip_tb -o tag_chip_sim \
  && ./obj_dir/tag_chip_sim \
  || { echo "simulation failed"; exit 1; }

exit 0

// ==== test/tag_chip_tb.sv ====
`timescale 1ns/1ps

module tag_chip_tb;

  import tag_pkg::*;
  import chip_cfg_pkg::*;

  logic       clk_i;
  logic       rst_n_i;
  tag_trace_s trace_i;
  logic       trace_v_i;
  logic       trace_ready_o;
  logic       tag_data_o;
  logic       done_o;
  logic       error_o;
  link_cfg_s  io_link_cfg_o;
  link_cfg_s  mem_link_cfg_o;
  core_cfg_s  core_cfg_o;
  core_cfg_s  clk_cfg_o;

  logic [35:0]  patterns [0:63];
  logic [31:0]  words [$];
  logic [31:0]  expected [1:5];
  logic [5:1]   have_expect;
  logic [31:0]  lcg_state;
  logic [31:0]  rnd_word;
  int unsigned  limit_cycles;
  int unsigned  busy_left;
  logic         done_model;
  tag_trace_s   word_fields;

  tag_chip_top #(.num_clients_p( 4 )) UUT
    (.clk_i         ( clk_i )
    ,.rst_n_i       ( rst_n_i )
    ,.trace_i       ( trace_i )
    ,.trace_v_i     ( trace_v_i )
    ,.trace_ready_o ( trace_ready_o )
    ,.tag_data_o    ( tag_data_o )
    ,.done_o        ( done_o )
    ,.error_o       ( error_o )
    ,.io_link_cfg_o ( io_link_cfg_o )
    ,.mem_link_cfg_o( mem_link_cfg_o )
    ,.core_cfg_o    ( core_cfg_o )
    ,.clk_cfg_o     ( clk_cfg_o )
    );

  always #20 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Helpers
  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    if (exp_val !== act_val)
    begin
      $display("mismatch %s: expected %h, actual %h", name, exp_val, act_val);
      $display("Finished with errors");
      $fatal(1, "value check failed");
    end
  endtask

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Holds the word until the DUT takes it
  task automatic drive_word(input logic [31:0] word, input int unsigned gap);
    for (int unsigned i = 0; i < gap; i++)
    begin
      trace_v_i <= 1'b0;
      @(posedge clk_i);
    end
    trace_i   <= tag_trace_s'(word[26:0]);
    trace_v_i <= 1'b1;
    @(negedge clk_i);
    while (!trace_ready_o)
      @(negedge clk_i);
    @(posedge clk_i);
  endtask

  ////////////////////////////////////////
  // Ready and done model sampled mid cycle
  always @(negedge clk_i)
  begin
    if (rst_n_i)
    begin
      check_value("trace_ready_o", 32'(busy_left == 0), 32'(trace_ready_o));
      check_value("done_o", 32'(done_model), 32'(done_o));
      if (busy_left != 0)
        busy_left--;
      else if (trace_v_i && !done_model)
      begin
        // Word transfers at the next rising edge
        if (trace_i.op == SEND)
          busy_left = 11 + 32'(trace_i.len);
        else if (trace_i.op == WAIT)
          busy_left = 32'(trace_i.payload);
        else if (trace_i.op == DONE)
          done_model = 1'b1;
      end
    end
  end

  // Watchdog
  initial
  begin
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge clk_i);
    $display("run timed out after %0d cycles", limit_cycles);
    $display("Finished with errors");
    $fatal(1, "timeout");
  end

  initial
  begin
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    trace_i      = '0;
    trace_v_i    = 1'b0;
    lcg_state    = 32'd32979;
    rnd_word     = '0;
    busy_left    = 0;
    done_model   = 1'b0;
    have_expect  = '0;
    limit_cycles = 0;

    for (int i = 0; i < 64; i++)
      patterns[i] = {4'hF, 32'(i)};
    $readmemh("test/tag_patterns.hex", patterns);
    for (int i = 0; i < 64; i++)
    begin
      if (patterns[i][35:32] == 4'h0)
        words.push_back(patterns[i][31:0]);
      else if (patterns[i][35:32] <= 4'h5)
      begin
        expected[int'(patterns[i][35:32])]    = patterns[i][31:0];
        have_expect[int'(patterns[i][35:32])] = 1'b1;
      end
    end
    if (have_expect != 5'b11111 || words.size() == 0)
    begin
      $display("pattern file lacks trace words or expected values");
      $display("Finished with errors");
      $fatal(1, "bad pattern file");
    end

    // Per word budget plus reset and margin
    limit_cycles = 110;
    foreach (words[i])
    begin
      word_fields = tag_trace_s'(words[i][26:0]);
      limit_cycles += 17;
      if (word_fields.op == SEND)
        limit_cycles += 32'(word_fields.len);
      else if (word_fields.op == WAIT)
        limit_cycles += 32'(word_fields.payload);
    end

    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;

    @(negedge clk_i);
    check_value("trace_ready_o", 32'd1, 32'(trace_ready_o));
    check_value("done_o", 32'd0, 32'(done_o));
    check_value("error_o", 32'd0, 32'(error_o));
    check_value("tag_data_o", 32'd0, 32'(tag_data_o));
    check_value("io_link_cfg_o", 32'd0, 32'(io_link_cfg_o));
    check_value("mem_link_cfg_o", 32'd0, 32'(mem_link_cfg_o));
    check_value("core_cfg_o", 32'd0, 32'(core_cfg_o));
    check_value("clk_cfg_o", 32'd0, 32'(clk_cfg_o));

    @(posedge clk_i);
    foreach (words[i])
    begin
      rnd_word = next_random();
      drive_word(words[i], {30'd0, rnd_word[17:16]});
    end
    trace_v_i <= 1'b0;

    @(negedge clk_i);
    while (!done_o)
      @(negedge clk_i);
    repeat (3) @(negedge clk_i);

    ////////////////////////////////////////
    // Final state
    check_value("io_link_cfg_o", expected[1], 32'(io_link_cfg_o));
    check_value("mem_link_cfg_o", expected[2], 32'(mem_link_cfg_o));
    check_value("core_cfg_o", expected[3], 32'(core_cfg_o));
    check_value("clk_cfg_o", expected[4], 32'(clk_cfg_o));
    check_value("error_o", expected[5], 32'(error_o));
    check_value("done_o", 32'd1, 32'(done_o));

    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== verilog/tag_chip_top.sv ====
`timescale 1ns/1ps

module tag_chip_top
  #(parameter int num_clients_p = 4)
  (input  logic                    clk_i
  ,input  logic                    rst_n_i
  ,input  tag_pkg::tag_trace_s     trace_i
  ,input  logic                    trace_v_i
  ,output logic                    trace_ready_o
  ,output logic                    tag_data_o
  ,output logic                    done_o
  ,output logic                    error_o
  ,output chip_cfg_pkg::link_cfg_s io_link_cfg_o
  ,output chip_cfg_pkg::link_cfg_s mem_link_cfg_o
  ,output chip_cfg_pkg::core_cfg_s core_cfg_o
  ,output chip_cfg_pkg::core_cfg_s clk_cfg_o
  );

  import tag_pkg::*;
  import chip_cfg_pkg::*;

  tag_write_s               write_lo;
  logic [num_clients_p-1:0] client_sel_lo;

  ////////////////////////////////////////
  // Trace replay and tag master
  tag_trace_replay replay
    (.clk_i        ( clk_i )
    ,.rst_n_i      ( rst_n_i )
    ,.trace_i      ( trace_i )
    ,.trace_v_i    ( trace_v_i )
    ,.trace_ready_o( trace_ready_o )
    ,.tag_data_o   ( tag_data_o )
    ,.done_o       ( done_o )
    );

  tag_master #(.num_clients_p( num_clients_p )) btm
    (.clk_i       ( clk_i )
    ,.rst_n_i     ( rst_n_i )
    ,.tag_data_i  ( tag_data_o )
    ,.write_o     ( write_lo )
    ,.client_sel_o( client_sel_lo )
    ,.error_o     ( error_o )
    );

  ////////////////////////////////////////
  // Clients 0 and 1 are links, 2 and 3 are core
  tag_client #(.payload_t( link_cfg_s )) io_link_client
    (.clk_i( clk_i ), .rst_n_i( rst_n_i ), .sel_i( client_sel_lo[0] )
    ,.write_i( write_lo ), .value_o( io_link_cfg_o ));

  tag_client #(.payload_t( link_cfg_s )) mem_link_client
    (.clk_i( clk_i ), .rst_n_i( rst_n_i ), .sel_i( client_sel_lo[1] )
    ,.write_i( write_lo ), .value_o( mem_link_cfg_o ));

  tag_client #(.payload_t( core_cfg_s )) core_client
    (.clk_i( clk_i ), .rst_n_i( rst_n_i ), .sel_i( client_sel_lo[2] )
    ,.write_i( write_lo ), .value_o( core_cfg_o ));

  tag_client #(.payload_t( core_cfg_s )) clk_client
    (.clk_i( clk_i ), .rst_n_i( rst_n_i ), .sel_i( client_sel_lo[3] )
    ,.write_i( write_lo ), .value_o( clk_cfg_o ));

endmodule

// ==== verilog/tag_client.sv ====
`timescale 1ns/1ps

module tag_client
  #(parameter type payload_t = logic [7:0])
  (input  logic                clk_i
  ,input  logic                rst_n_i
  ,input  logic                sel_i
  ,input  tag_pkg::tag_write_s write_i
  ,output payload_t            value_o
  );

  import tag_pkg::*;

  localparam int width_lp = $bits(payload_t);

  logic [tag_max_payload_width_gp-1:0] masked;
  payload_t                            value_r;

  // Bits past len read as zero
  assign masked  = write_i.payload & tag_len_mask(write_i.len);
  assign value_o = value_r;

  ////////////////////////////////////////
  // Configuration register
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      value_r <= '0;
    else if (sel_i)
    begin
      if (write_i.data_not_reset)
        value_r <= payload_t'(masked[width_lp-1:0]);
      else
        value_r <= '0;
    end
  end

endmodule

// ==== verilog/tag_master.sv ====
`timescale 1ns/1ps

module tag_master
  #(parameter int num_clients_p = 4)
  (input  logic                     clk_i
  ,input  logic                     rst_n_i
  ,input  logic                     tag_data_i
  ,output tag_pkg::tag_write_s      write_o
  ,output logic [num_clients_p-1:0] client_sel_o
  ,output logic                     error_o
  );

  import tag_pkg::*;

  typedef enum logic [1:0] {st_idle, st_hdr, st_pay} state_e;

  // Header as it arrives after the start bit
  typedef struct packed
  {
    logic [tag_len_width_gp-1:0]      len;
    logic [tag_lg_max_clients_gp-1:0] client_id;
    logic                             data_not_reset;
  } header_s;

  localparam int hdr_bits_lp      = $bits(header_s);
  localparam int hdr_cnt_width_lp = $clog2(hdr_bits_lp);
  localparam int pay_idx_width_lp = $clog2(tag_max_payload_width_gp);

  state_e                              state_r;
  header_s                             hdr_r;
  header_s                             hdr_n;
  header_s                             hdr_cur;
  logic [hdr_cnt_width_lp-1:0]         hdr_cnt_r;
  logic [tag_len_width_gp-1:0]         pay_cnt_r;
  logic [tag_max_payload_width_gp-1:0] pay_r;
  logic [tag_max_payload_width_gp-1:0] pay_n;
  logic                                last_hdr;
  logic                                last_pay;
  logic                                pkt_end;
  logic                                bad_id;
  logic [num_clients_p-1:0]            sel_n;
  tag_write_s                          write_r;
  logic [num_clients_p-1:0]            sel_r;
  logic                                error_r;

  assign write_o      = write_r;
  assign client_sel_o = sel_r;
  assign error_o      = error_r;

  ////////////////////////////////////////
  // Next header, payload and select
  always_comb
  begin
    hdr_n = header_s'({tag_data_i, hdr_r[hdr_bits_lp-1:1]});
    pay_n = pay_r;
    if (pay_cnt_r < tag_len_width_gp'(tag_max_payload_width_gp))
      pay_n[pay_cnt_r[pay_idx_width_lp-1:0]] = tag_data_i;

    last_hdr = (state_r == st_hdr) && (hdr_cnt_r == hdr_cnt_width_lp'(hdr_bits_lp - 1));
    last_pay = (state_r == st_pay) && (pay_cnt_r == hdr_r.len - 1'b1);
    hdr_cur  = (state_r == st_hdr) ? hdr_n : hdr_r;
    pkt_end  = (last_hdr && (hdr_n.len == '0)) || last_pay;

    bad_id = int'(hdr_cur.client_id) >= num_clients_p;
    for (int i = 0; i < num_clients_p; i++)
      sel_n[i] = (int'(hdr_cur.client_id) == i);
  end

  always_ff @(posedge clk_i)
  begin
    if (state_r == st_idle)
      pay_r <= '0;
    else if (state_r == st_pay)
      pay_r <= pay_n;

    if (state_r == st_hdr)
      hdr_r <= hdr_n;

    if (pkt_end)
    begin
      write_r.data_not_reset <= hdr_cur.data_not_reset;
      write_r.len            <= hdr_cur.len;
      write_r.payload        <= (state_r == st_pay) ? pay_n : '0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_r   <= st_idle;
      hdr_cnt_r <= '0;
      pay_cnt_r <= '0;
      sel_r     <= '0;
      error_r   <= 1'b0;
    end
    else
    begin
      sel_r <= (pkt_end && !bad_id) ? sel_n : '0;
      if (pkt_end && bad_id)
        error_r <= 1'b1;

      case (state_r)
        st_idle:
        begin
          hdr_cnt_r <= '0;
          pay_cnt_r <= '0;
          if (tag_data_i)
            state_r <= st_hdr;
        end
        st_hdr:
        begin
          hdr_cnt_r <= hdr_cnt_r + 1'b1;
          if (last_hdr)
            state_r <= (hdr_n.len == '0) ? st_idle : st_pay;
        end
        default:
        begin
          pay_cnt_r <= pay_cnt_r + 1'b1;
          if (last_pay)
            state_r <= st_idle;
        end
      endcase
    end
  end

endmodule

// ==== verilog/tag_trace_replay.sv ====
`timescale 1ns/1ps

module tag_trace_replay
  (input  logic                clk_i
  ,input  logic                rst_n_i
  ,input  tag_pkg::tag_trace_s trace_i
  ,input  logic                trace_v_i
  ,output logic                trace_ready_o
  ,output logic                tag_data_o
  ,output logic                done_o
  );

  import tag_pkg::*;

  typedef enum logic [1:0] {st_idle, st_shift, st_wait, st_done} state_e;

  // Bit 0 leaves first
  typedef struct packed
  {
    logic [tag_max_payload_width_gp-1:0] payload;
    logic [tag_len_width_gp-1:0]         len;
    logic [tag_lg_max_clients_gp-1:0]    client_id;
    logic                                data_not_reset;
    logic                                start;
  } packet_s;

  localparam int pkt_width_lp = $bits(packet_s);
  localparam int hdr_bits_lp  = pkt_width_lp - tag_max_payload_width_gp;
  localparam int cnt_width_lp = tag_max_payload_width_gp;

  state_e                  state_r;
  logic [pkt_width_lp-1:0] sreg_r;
  logic [cnt_width_lp-1:0] cnt_r;
  logic                    tag_data_r;
  packet_s                 pkt_n;
  logic                    accept;

  assign trace_ready_o = (state_r == st_idle) || (state_r == st_done);
  assign accept        = trace_v_i & trace_ready_o;
  assign tag_data_o    = tag_data_r;
  assign done_o        = (state_r == st_done);

  // Payload above len is zeroed so the line falls back to idle
  always_comb
  begin
    pkt_n.payload        = trace_i.payload & tag_len_mask(trace_i.len);
    pkt_n.len            = trace_i.len;
    pkt_n.client_id      = trace_i.client_id;
    pkt_n.data_not_reset = trace_i.data_not_reset;
    pkt_n.start          = 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      sreg_r <= pkt_n;
    else
      sreg_r <= sreg_r >> 1;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_r    <= st_idle;
      cnt_r      <= '0;
      tag_data_r <= 1'b0;
    end
    else
    begin
      tag_data_r <= 1'b0;
      case (state_r)
        st_idle:
        begin
          if (trace_v_i)
          begin
            case (trace_i.op)
              SEND:
              begin
                // One extra trailing cycle drives the idle 0
                state_r <= st_shift;
                cnt_r   <= cnt_width_lp'(hdr_bits_lp + 1) + cnt_width_lp'(trace_i.len);
              end
              WAIT:
              begin
                if (trace_i.payload != '0)
                begin
                  state_r <= st_wait;
                  cnt_r   <= trace_i.payload;
                end
              end
              DONE:
                state_r <= st_done;
              default:
                state_r <= st_idle;
            endcase
          end
        end
        st_shift:
        begin
          tag_data_r <= sreg_r[0];
          cnt_r      <= cnt_r - 1'b1;
          if (cnt_r == cnt_width_lp'(1))
            state_r <= st_idle;
        end
        st_wait:
        begin
          cnt_r <= cnt_r - 1'b1;
          if (cnt_r == cnt_width_lp'(1))
            state_r <= st_idle;
        end
        default:
          state_r <= st_done;
      endcase
    end
  end

endmodule

// ==== verilog/chip_cfg_pkg.sv ====
package chip_cfg_pkg;

  ////////////////////////////////////////
  // Link client payload
  typedef struct packed
  {
    logic       enable;
    logic [3:0] credits;
    logic [2:0] width_sel;
  } link_cfg_s;

  ////////////////////////////////////////
  // Core client payload
  typedef struct packed
  {
    logic       reset;
    logic [6:0] clk_div;
    logic [7:0] mode;
  } core_cfg_s;

endpackage

// ==== verilog/tag_pkg.sv ====
package tag_pkg;

  ////////////////////////////////////////
  // Protocol widths
  parameter int tag_max_payload_width_gp = 16;
  parameter int tag_lg_max_clients_gp    = 3;
  parameter int tag_len_width_gp         = 5;

  typedef enum logic [1:0]
  {
    NOP  = 2'd0,
    SEND = 2'd1,
    WAIT = 2'd2,
    DONE = 2'd3
  } tag_op_e;

  // For WAIT the payload holds the idle count
  typedef struct packed
  {
    tag_op_e                             op;
    logic [tag_lg_max_clients_gp-1:0]    client_id;
    logic                                data_not_reset;
    logic [tag_len_width_gp-1:0]         len;
    logic [tag_max_payload_width_gp-1:0] payload;
  } tag_trace_s;

  // Packet as seen by the clients
  typedef struct packed
  {
    logic                                data_not_reset;
    logic [tag_len_width_gp-1:0]         len;
    logic [tag_max_payload_width_gp-1:0] payload;
  } tag_write_s;

  // Ones below len, zeros above
  function automatic logic [tag_max_payload_width_gp-1:0] tag_len_mask
    (input logic [tag_len_width_gp-1:0] len);
    logic [tag_max_payload_width_gp-1:0] mask;
    mask = '0;
    for (int i = 0; i < tag_max_payload_width_gp; i++)
      mask[i] = (i < int'(len));
    return mask;
  endfunction

endpackage
